// File: include/mem_settings.svh
// Width and depth macros for the data-memory path, included by packages and RTL.
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// Data word width in bits.
`define MEM_XLEN 32

// Byte address width in bits.
`define MEM_ADDR_BITS 32

// Depth of the word array.
`define MEM_RAM_WORDS 256

// Byte lanes per data word.
`define MEM_BYTES_PER_WORD 4

`endif

// File: logic/mem_data_pkg.sv
// Data, address and lane-mask types shared by the memory path; compile before the RTL.
`include "mem_settings.svh"

package mem_data_pkg;

    // One data word.
    typedef logic [`MEM_XLEN-1:0] word_t;

    // Byte address as seen by the core.
    typedef logic [`MEM_ADDR_BITS-1:0] addr_t;

    // One enable bit per byte lane.
    typedef logic [`MEM_BYTES_PER_WORD-1:0] byte_mask_t;

    // Word index into the array.
    // Upper address bits above this alias.
    typedef logic [$clog2(`MEM_RAM_WORDS)-1:0] word_index_t;

endpackage

// File: logic/mem_access_pkg.sv
// Access-size and state-machine enums for the memory path; compile before the RTL.
package mem_access_pkg;

    // Width of one load or store.
    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } access_size_t;

    // Load/store unit states.
    // Wait holds the bridge request, finish is the done or fault cycle.
    typedef enum logic [1:0] {
        lsu_idle   = 2'd0,
        lsu_wait   = 2'd1,
        lsu_finish = 2'd2
    } lsu_state_t;

    // Bridge states.
    // Access carries the enable pulse.
    // Data and ready both return ready, for reads and writes.
    typedef enum logic [1:0] {
        br_idle   = 2'd0,
        br_access = 2'd1,
        br_data   = 2'd2,
        br_ready  = 2'd3
    } bridge_state_t;

endpackage

// File: logic/ram_array.sv
// Word memory with byte-lane writes and registered reads, standing in for external RAM.
`include "mem_settings.svh"

module ram_array (
    input  logic                      ramclk,
    input  logic                      mem_read_en,
    input  logic                      mem_write_en,
    input  mem_data_pkg::word_index_t mem_word,
    input  mem_data_pkg::byte_mask_t  mem_mask,
    input  mem_data_pkg::word_t       mem_wdata,
    output mem_data_pkg::word_t       mem_rdata
);
    import mem_data_pkg::*;

    // Storage, contents unknown at power-up.
    word_t mem [0:`MEM_RAM_WORDS-1];

    // Masked lane writes.
    always_ff @(posedge ramclk) begin
        if (mem_write_en) begin
            for (int i = 0; i < `MEM_BYTES_PER_WORD; i++) begin
                if (mem_mask[i]) begin
                    mem[mem_word][i*8 +: 8] <= mem_wdata[i*8 +: 8];
                end
            end
        end
    end

    // Read data one cycle after the enable.
    // Held between reads.
    always_ff @(posedge ramclk) begin
        if (mem_read_en) begin
            mem_rdata <= mem[mem_word];
        end
    end

endmodule

// File: logic/digital_ram.sv
// Bridge from the held read/write request to one-cycle enables on the word array.
`include "mem_settings.svh"

module digital_ram (
    input  logic                         ramclk,
    input  logic                         rst,
    input  logic                         mem_io_read,
    input  logic                         mem_io_write,
    input  mem_data_pkg::addr_t          mem_io_addr,
    input  mem_data_pkg::word_t          mem_io_wdata,
    input  mem_access_pkg::access_size_t io_byte_size,
    output logic                         mem_io_ready,
    output mem_data_pkg::word_t          mem_io_rdata,
    output logic                         mem_read_en,
    output logic                         mem_write_en,
    output mem_data_pkg::word_index_t    mem_word,
    output mem_data_pkg::byte_mask_t     mem_mask,
    output mem_data_pkg::word_t          mem_wdata,
    input  mem_data_pkg::word_t          mem_rdata
);
    import mem_data_pkg::*;
    import mem_access_pkg::*;

    bridge_state_t state;
    logic          start;
    logic [1:0]    offset;
    byte_mask_t    lane_mask;
    word_t         placed_wdata;

    // Level only starts an access from idle.
    // Still-high level in the ready cycle is ignored.
    assign start  = (state == br_idle) && (mem_io_read || mem_io_write);
    assign offset = mem_io_addr[1:0];

    // Array output is already lane-placed.
    assign mem_io_rdata = mem_rdata;

    // Byte-lane mask from size and offset.
    always_comb begin
        case (io_byte_size)
            size_byte: lane_mask = byte_mask_t'(1) << offset;
            size_half: lane_mask = byte_mask_t'(3) << {offset[1], 1'b0};
            default:   lane_mask = '1;
        endcase
    end

    // Low byte or half copied into every lane.
    // The mask picks which lanes land.
    always_comb begin
        case (io_byte_size)
            size_byte: placed_wdata = {`MEM_BYTES_PER_WORD{mem_io_wdata[7:0]}};
            size_half: placed_wdata = {(`MEM_BYTES_PER_WORD/2){mem_io_wdata[15:0]}};
            default:   placed_wdata = mem_io_wdata;
        endcase
    end

    // Access sequencer.
    always_ff @(posedge ramclk or negedge rst) begin
        if (!rst) begin
            state        <= br_idle;
            mem_read_en  <= 1'b0;
            mem_write_en <= 1'b0;
            mem_io_ready <= 1'b0;
        end else begin
            mem_read_en  <= 1'b0;
            mem_write_en <= 1'b0;
            mem_io_ready <= 1'b0;
            case (state)
                br_idle: begin
                    if (start) begin
                        // Read wins if both are seen.
                        mem_read_en  <= mem_io_read;
                        mem_write_en <= mem_io_write && !mem_io_read;
                        state        <= br_access;
                    end
                end
                br_access: begin
                    // Enable pulse cycle.
                    // Read data registers at this edge.
                    mem_io_ready <= 1'b1;
                    state        <= mem_read_en ? br_data : br_ready;
                end
                br_data: begin
                    state <= br_idle;
                end
                br_ready: begin
                    state <= br_idle;
                end
                default: begin
                    state <= br_idle;
                end
            endcase
        end
    end

    // Array address, mask and data, held with the pulse.
    always_ff @(posedge ramclk) begin
        if (start) begin
            mem_word  <= mem_io_addr[2 +: $bits(word_index_t)];
            mem_mask  <= lane_mask;
            mem_wdata <= placed_wdata;
        end
    end

endmodule

// File: logic/load_store_unit.sv
// Core-side load/store unit: alignment check, held bridge request and load extension.
`include "mem_settings.svh"

module load_store_unit (
    input  logic                         ramclk,
    input  logic                         rst,
    input  logic                         req,
    input  logic                         write,
    input  logic                         is_signed,
    input  mem_access_pkg::access_size_t size,
    input  mem_data_pkg::addr_t          addr,
    input  mem_data_pkg::word_t          wdata,
    output logic                         done,
    output logic                         fault,
    output logic                         busy,
    output mem_data_pkg::word_t          rdata,
    output logic                         mem_io_read,
    output logic                         mem_io_write,
    output mem_data_pkg::addr_t          mem_io_addr,
    output mem_data_pkg::word_t          mem_io_wdata,
    output mem_access_pkg::access_size_t io_byte_size,
    input  logic                         mem_io_ready,
    input  mem_data_pkg::word_t          mem_io_rdata
);
    import mem_data_pkg::*;
    import mem_access_pkg::*;

    lsu_state_t state;
    logic       sign_q;
    logic       accept;
    logic       misaligned;
    word_t      shifted;
    word_t      load_value;

    // A new request only counts while idle.
    assign accept = req && (state == lsu_idle);

    // High from the cycle after accept through the done or fault cycle.
    assign busy = (state != lsu_idle);

    // Natural alignment per access size.
    always_comb begin
        case (size)
            size_half: misaligned = addr[0];
            size_word: misaligned = (addr[1:0] != 2'b00);
            default:   misaligned = 1'b0;
        endcase
    end

    // Returned word is lane-placed.
    // Move the addressed lanes down to bit 0.
    assign shifted = mem_io_rdata >> {mem_io_addr[1:0], 3'b000};

    // Sign or zero extension to the access size.
    always_comb begin
        case (io_byte_size)
            size_byte: begin
                load_value = {{(`MEM_XLEN-8){sign_q & shifted[7]}}, shifted[7:0]};
            end
            size_half: begin
                load_value = {{(`MEM_XLEN-16){sign_q & shifted[15]}}, shifted[15:0]};
            end
            default: begin
                load_value = shifted;
            end
        endcase
    end

    // Control FSM.
    always_ff @(posedge ramclk or negedge rst) begin
        if (!rst) begin
            state        <= lsu_idle;
            mem_io_read  <= 1'b0;
            mem_io_write <= 1'b0;
            done         <= 1'b0;
            fault        <= 1'b0;
        end else begin
            // Strobes last one cycle.
            done  <= 1'b0;
            fault <= 1'b0;
            case (state)
                lsu_idle: begin
                    if (accept && misaligned) begin
                        // No memory access at all.
                        fault <= 1'b1;
                        state <= lsu_finish;
                    end else if (accept) begin
                        mem_io_read  <= !write;
                        mem_io_write <= write;
                        state        <= lsu_wait;
                    end
                end
                lsu_wait: begin
                    // Level held until the bridge answers.
                    if (mem_io_ready) begin
                        mem_io_read  <= 1'b0;
                        mem_io_write <= 1'b0;
                        done         <= 1'b1;
                        state        <= lsu_finish;
                    end
                end
                lsu_finish: begin
                    state <= lsu_idle;
                end
                default: begin
                    state <= lsu_idle;
                end
            endcase
        end
    end

    // Request payload, latched on accept.
    always_ff @(posedge ramclk) begin
        if (accept) begin
            mem_io_addr  <= addr;
            mem_io_wdata <= wdata;
            io_byte_size <= size;
            sign_q       <= is_signed;
        end
    end

    // Load result, captured in the ready cycle.
    always_ff @(posedge ramclk) begin
        if ((state == lsu_wait) && mem_io_ready && mem_io_read) begin
            rdata <= load_value;
        end
    end

endmodule

// File: logic/mem_system.sv
// Top of the data-memory path: load/store unit, bridge and word array wired together.
module mem_system (
    input  logic                         ramclk,
    input  logic                         rst,
    input  logic                         req,
    input  logic                         write,
    input  logic                         is_signed,
    input  mem_access_pkg::access_size_t size,
    input  mem_data_pkg::addr_t          addr,
    input  mem_data_pkg::word_t          wdata,
    output logic                         done,
    output logic                         fault,
    output logic                         busy,
    output mem_data_pkg::word_t          rdata
);
    import mem_data_pkg::*;
    import mem_access_pkg::*;

    // Held request between unit and bridge.
    logic         mem_io_read;
    logic         mem_io_write;
    addr_t        mem_io_addr;
    word_t        mem_io_wdata;
    access_size_t io_byte_size;
    logic         mem_io_ready;
    word_t        mem_io_rdata;

    // Pulsed access between bridge and array.
    logic         mem_read_en;
    logic         mem_write_en;
    word_index_t  mem_word;
    byte_mask_t   mem_mask;
    word_t        mem_wdata;
    word_t        mem_rdata;

    load_store_unit i_load_store_unit (
        .ramclk      (ramclk),
        .rst         (rst),
        .req         (req),
        .write       (write),
        .is_signed   (is_signed),
        .size        (size),
        .addr        (addr),
        .wdata       (wdata),
        .done        (done),
        .fault       (fault),
        .busy        (busy),
        .rdata       (rdata),
        .mem_io_read (mem_io_read),
        .mem_io_write(mem_io_write),
        .mem_io_addr (mem_io_addr),
        .mem_io_wdata(mem_io_wdata),
        .io_byte_size(io_byte_size),
        .mem_io_ready(mem_io_ready),
        .mem_io_rdata(mem_io_rdata)
    );

    digital_ram i_digital_ram (
        .ramclk      (ramclk),
        .rst         (rst),
        .mem_io_read (mem_io_read),
        .mem_io_write(mem_io_write),
        .mem_io_addr (mem_io_addr),
        .mem_io_wdata(mem_io_wdata),
        .io_byte_size(io_byte_size),
        .mem_io_ready(mem_io_ready),
        .mem_io_rdata(mem_io_rdata),
        .mem_read_en (mem_read_en),
        .mem_write_en(mem_write_en),
        .mem_word    (mem_word),
        .mem_mask    (mem_mask),
        .mem_wdata   (mem_wdata),
        .mem_rdata   (mem_rdata)
    );

    ram_array i_ram_array (
        .ramclk      (ramclk),
        .mem_read_en (mem_read_en),
        .mem_write_en(mem_write_en),
        .mem_word    (mem_word),
        .mem_mask    (mem_mask),
        .mem_wdata   (mem_wdata),
        .mem_rdata   (mem_rdata)
    );

endmodule

// File: testbench/tb_clock_gen.sv
// Clock and reset source for the testbench: free-running ramclk, rst held low after start.
module tb_clock_gen #(
    parameter int period_ns    = 10,
    parameter int reset_cycles = 10
) (
    output logic ramclk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 1ps;

    // Free-running clock.
    initial begin
        ramclk = 1'b0;
        forever #(period_ns / 2) ramclk = ~ramclk;
    end

    // Active-low reset, released just after an edge.
    initial begin
        rst = 1'b0;
        repeat (reset_cycles) @(posedge ramclk);
        #1 rst = 1'b1;
    end

endmodule

// File: testbench/mem_system_properties.sv
// Checker bound into mem_system that keeps a shadow word array and asserts timing and data.
`include "mem_settings.svh"

module mem_system_properties (
    input logic                         ramclk,
    input logic                         rst,
    input logic                         req,
    input logic                         write,
    input logic                         is_signed,
    input mem_access_pkg::access_size_t size,
    input mem_data_pkg::addr_t          addr,
    input mem_data_pkg::word_t          wdata,
    input logic                         done,
    input logic                         fault,
    input logic                         busy,
    input mem_data_pkg::word_t          rdata,
    input logic                         mem_read_en,
    input logic                         mem_write_en
);
    timeunit 1ns;
    timeprecision 1ps;
    import mem_data_pkg::*;
    import mem_access_pkg::*;

    // Model of the array contents.
    word_t        shadow [0:`MEM_RAM_WORDS-1];
    int unsigned  fail_count = 0;
    logic         seen_req;
    logic         accept;
    logic         aligned;
    logic [3:0]   acc_pipe;
    logic         mis_pipe;
    logic         op_write;
    logic         op_signed;
    access_size_t op_size;
    addr_t        op_addr;
    word_t        op_wdata;
    word_index_t  op_index;
    logic [1:0]   op_offset;
    word_t        stored;
    word_t        merged;
    word_t        load_expect;
    logic [7:0]   lane_byte;
    logic [15:0]  lane_half;

    // Accepted only while the unit is idle.
    assign accept    = req && !busy;
    assign op_index  = word_index_t'(op_addr >> 2);
    assign op_offset = op_addr[1:0];

    // Halves align on even addresses and words on multiples of four.
    always_comb begin
        case (size)
            size_word: aligned = (addr[1:0] == 2'b00);
            size_half: aligned = !addr[0];
            default:   aligned = 1'b1;
        endcase
    end

    // Request history for the strobe timing.
    always_ff @(posedge ramclk or negedge rst) begin
        if (!rst) begin
            seen_req <= 1'b0;
            acc_pipe <= '0;
            mis_pipe <= 1'b0;
        end else begin
            seen_req <= seen_req || req;
            acc_pipe <= {acc_pipe[2:0], accept && aligned};
            mis_pipe <= accept && !aligned;
        end
    end

    // Request in flight.
    always_ff @(posedge ramclk) begin
        if (accept) begin
            op_write  <= write;
            op_signed <= is_signed;
            op_size   <= size;
            op_addr   <= addr;
            op_wdata  <= wdata;
        end
    end

    // Store merge and load extension from the shadow word.
    always_comb begin
        stored    = shadow[op_index];
        lane_byte = stored[{op_offset, 3'b000} +: 8];
        lane_half = stored[{op_offset[1], 4'b0000} +: 16];
        merged    = stored;
        case (op_size)
            size_byte: merged[{op_offset, 3'b000} +: 8] = op_wdata[7:0];
            size_half: merged[{op_offset[1], 4'b0000} +: 16] = op_wdata[15:0];
            default:   merged = op_wdata;
        endcase
        if (op_size == size_byte) begin
            if (op_signed && lane_byte[7]) begin
                load_expect = {{(`MEM_XLEN-8){1'b1}}, lane_byte};
            end else begin
                load_expect = {{(`MEM_XLEN-8){1'b0}}, lane_byte};
            end
        end else if (op_size == size_half) begin
            if (op_signed && lane_half[15]) begin
                load_expect = {{(`MEM_XLEN-16){1'b1}}, lane_half};
            end else begin
                load_expect = {{(`MEM_XLEN-16){1'b0}}, lane_half};
            end
        end else begin
            load_expect = stored;
        end
    end

    // Shadow follows each completed store.
    always_ff @(posedge ramclk) begin
        if (done && op_write) begin
            shadow[op_index] <= merged;
        end
    end

    quiet_before_req: assert property (@(posedge ramclk) !seen_req |-> !done && !fault && !busy)
        else begin
            fail_count++;
            $error("done, fault or busy went high before any request");
        end

    done_timing: assert property (@(posedge ramclk) disable iff (!rst) done == acc_pipe[3])
        else begin
            fail_count++;
            $error("done is not exactly 4 cycles after an accepted aligned request");
        end

    fault_timing: assert property (@(posedge ramclk) disable iff (!rst) fault == mis_pipe)
        else begin
            fail_count++;
            $error("fault is not exactly 1 cycle after a misaligned request");
        end

    // Busy covers the cycles after accept up to the done or fault cycle.
    busy_window: assert property (@(posedge ramclk) disable iff (!rst)
        busy == ((acc_pipe != 4'b0000) || mis_pipe))
        else begin
            fail_count++;
            $error("busy is not high exactly from accept through the done or fault cycle");
        end

    load_data: assert property (@(posedge ramclk) disable iff (!rst)
        done && !op_write |-> rdata == load_expect)
        else begin
            fail_count++;
            $error("CHECK FAILED rdata: got %h expected %h", $sampled(rdata),
                $sampled(load_expect));
        end

    // Array touched only by an aligned access in flight.
    enable_scope: assert property (@(posedge ramclk) disable iff (!rst)
        (mem_read_en || mem_write_en) |-> acc_pipe[1])
        else begin
            fail_count++;
            $error("array enable seen without an aligned request in flight");
        end

endmodule

// File: testbench/mem_system_tb.sv
// Top testbench for the data-memory path; drives core requests, bound assertions check them.
`include "mem_settings.svh"

module mem_system_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import mem_data_pkg::*;
    import mem_access_pkg::*;

    localparam int reset_cycles = 10;
    localparam int quiet_cycles = 20;
    localparam int n_words      = 16;
    localparam int n_mixed      = 24;
    localparam int wait_limit   = 20;
    // Requests over all tests.
    localparam int n_requests   = 2 * n_words + 5 + 13 + 5 + n_mixed;
    localparam int watchdog_ns  = (n_requests * 10 + reset_cycles + quiet_cycles) * 10;
    localparam addr_t range_mask = addr_t'(`MEM_RAM_WORDS * `MEM_BYTES_PER_WORD - 1);

    logic         ramclk;
    logic         rst;
    logic         req;
    logic         write;
    logic         is_signed;
    access_size_t size;
    addr_t        addr;
    word_t        wdata;
    logic         done;
    logic         fault;
    logic         busy;
    word_t        rdata;

    logic [31:0]  rng_state;
    addr_t        word_addr [n_words];
    int unsigned  tests_passed;
    int unsigned  tests_failed;
    int unsigned  local_errors;
    int unsigned  fails_at_start;

    tb_clock_gen #(.period_ns(10), .reset_cycles(reset_cycles)) i_clock_gen (
        .ramclk(ramclk),
        .rst   (rst)
    );

    mem_system i_mem_system (
        .ramclk   (ramclk),
        .rst      (rst),
        .req      (req),
        .write    (write),
        .is_signed(is_signed),
        .size     (size),
        .addr     (addr),
        .wdata    (wdata),
        .done     (done),
        .fault    (fault),
        .busy     (busy),
        .rdata    (rdata)
    );

    bind mem_system mem_system_properties i_props (
        .ramclk(ramclk), .rst(rst), .req(req), .write(write), .is_signed(is_signed),
        .size(size), .addr(addr), .wdata(wdata), .done(done), .fault(fault),
        .busy(busy), .rdata(rdata), .mem_read_en(mem_read_en), .mem_write_en(mem_write_en)
    );

    // xorshift32 step on the shared state.
    function automatic logic [31:0] random_word();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // One request, then wait for the unit to go idle.
    task automatic issue(input logic wr, input access_size_t sz, input logic sgn,
                         input addr_t a, input word_t d);
        int cycles;
        write     = wr;
        size      = sz;
        is_signed = sgn;
        addr      = a;
        wdata     = d;
        req       = 1'b1;
        @(posedge ramclk);
        #1;
        req    = 1'b0;
        cycles = 0;
        while (busy && cycles < wait_limit) begin
            @(posedge ramclk);
            #1;
            cycles++;
        end
        if (busy) begin
            $display("request at address %h never left busy", a);
            local_errors++;
        end
    endtask

    // Per-test result from the assertion failure counter.
    task automatic finish_test(input string name);
        int unsigned errors;
        errors = i_mem_system.i_props.fail_count - fails_at_start + local_errors;
        if (errors == 0) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors);
        end
        fails_at_start = i_mem_system.i_props.fail_count;
        local_errors   = 0;
    endtask

    // Hung run guard.
    initial begin
        #(watchdog_ns);
        $display("timeout after %0d ns, tests did not finish", watchdog_ns);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        logic [31:0]  r;
        access_size_t sz;
        logic [1:0]   off;
        addr_t        base;
        req            = 1'b0;
        write          = 1'b0;
        is_signed      = 1'b0;
        size           = size_word;
        addr           = '0;
        wdata          = '0;
        rng_state      = 32'he7cd;
        tests_passed   = 0;
        tests_failed   = 0;
        local_errors   = 0;
        fails_at_start = 0;
        @(posedge rst);
        repeat (quiet_cycles) @(posedge ramclk);
        #1;
        finish_test("reset_quiet");

        // Word stores, then word loads of the same places.
        for (int i = 0; i < n_words; i++) begin
            word_addr[i] = random_word() & range_mask & ~addr_t'(3);
            issue(1'b1, size_word, 1'b0, word_addr[i], random_word());
        end
        for (int i = 0; i < n_words; i++) begin
            issue(1'b0, size_word, 1'b0, word_addr[i], '0);
        end
        finish_test("word_roundtrip");

        // Byte and half stores into one word.
        base = word_addr[0];
        issue(1'b1, size_word, 1'b0, base, random_word());
        issue(1'b1, size_byte, 1'b0, base | addr_t'(1), random_word());
        issue(1'b1, size_half, 1'b0, base | addr_t'(2), random_word());
        issue(1'b0, size_word, 1'b0, base, '0);
        issue(1'b0, size_byte, 1'b0, base, '0);
        finish_test("lane_merge");

        // Every lane has its top bit set.
        base = word_addr[1];
        issue(1'b1, size_word, 1'b0, base, random_word() | 32'h8080_8080);
        for (int o = 0; o < 4; o++) begin
            issue(1'b0, size_byte, 1'b1, base | addr_t'(o), '0);
            issue(1'b0, size_byte, 1'b0, base | addr_t'(o), '0);
        end
        for (int o = 0; o < 4; o += 2) begin
            issue(1'b0, size_half, 1'b1, base | addr_t'(o), '0);
            issue(1'b0, size_half, 1'b0, base | addr_t'(o), '0);
        end
        finish_test("sign_extend");

        // Faults, then the word is read back untouched.
        base = word_addr[2];
        issue(1'b1, size_half, 1'b0, base | addr_t'(1), random_word());
        issue(1'b1, size_word, 1'b0, base | addr_t'(2), random_word());
        issue(1'b0, size_word, 1'b0, base | addr_t'(3), '0);
        issue(1'b0, size_half, 1'b1, base | addr_t'(1), '0);
        issue(1'b0, size_word, 1'b0, base, '0);
        finish_test("misaligned");

        // Random aligned mix over words already written.
        for (int i = 0; i < n_mixed; i++) begin
            r = random_word();
            case (r[5:4])
                2'd0:    sz = size_byte;
                2'd1:    sz = size_half;
                default: sz = size_word;
            endcase
            off = r[7:6];
            if (sz == size_half) begin
                off[0] = 1'b0;
            end else if (sz == size_word) begin
                off = 2'b00;
            end
            issue(r[8], sz, r[9], word_addr[r[3:0]] | addr_t'(off), random_word());
        end
        finish_test("mixed_timing");

        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+include
logic/mem_data_pkg.sv
logic/mem_access_pkg.sv
logic/ram_array.sv
logic/digital_ram.sv
logic/load_store_unit.sv
logic/mem_system.sv
testbench/tb_clock_gen.sv
testbench/mem_system_properties.sv
testbench/mem_system_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the memory-path simulation with Verilator, runs it and checks the log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module mem_system_tb -f verilog.f -o mem_system_sim

status=0
./obj_dir/mem_system_sim +verilator+error+limit+1000 > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Simulation failed" sim.log; then
    echo "run failed"
    exit 1
fi
if ! grep -q "Simulation passed" sim.log; then
    echo "run ended without a result"
    exit 1
fi
